// ==== icache.f ====
+incdir+verif
common/icache_pkg.sv
common/icache_bus_pkg.sv
icache_ctrl/refill_collector.sv
icache_ctrl/icache_ctrl.sv
src/icache_ways.sv
src/icache_top.sv
verif/tb_icache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the icache testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_icache -f icache.f -Mdir obj_dir &&
./obj_dir/Vtb_icache || { echo "simulation did not pass"; exit 1; }

// ==== verif/tb_icache_cases.svh ====
/*
 * icache case table: fetches and cache operations in order,
 * each with the hit or miss the testbench expects
 */
`ifndef TB_ICACHE_CASES_SVH
`define TB_ICACHE_CASES_SVH

// columns: is_cacop, op, addr, uncached, exp_hit
// op is only used by cacop rows, exp_hit only by fetch rows
typedef struct packed {
    logic        is_cacop;
    cacop_op_e   op;
    fetch_addr_t addr;
    logic        uncached;
    logic        exp_hit;
} case_t;

localparam int NUM_CASES = 32;

case_t case_tab [NUM_CASES] = '{
    // cold miss, then other offsets of the same line
    '{1'b0, CACOP_INIT,      32'h0001_2100, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0001_2104, 1'b0, 1'b1},
    '{1'b0, CACOP_INIT,      32'h0001_210C, 1'b0, 1'b1},
    // second tag in set 0x10
    '{1'b0, CACOP_INIT,      32'h0003_4100, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0001_2108, 1'b0, 1'b1},
    '{1'b0, CACOP_INIT,      32'h0003_4100, 1'b0, 1'b1},
    '{1'b0, CACOP_INIT,      32'h0001_2100, 1'b0, 1'b1},
    // third tag evicts 0x34, then 0x56, then 0x12
    '{1'b0, CACOP_INIT,      32'h0005_6100, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0001_2100, 1'b0, 1'b1},
    '{1'b0, CACOP_INIT,      32'h0003_4100, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0005_6100, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0003_4100, 1'b0, 1'b1},
    // uncached read does not allocate
    '{1'b0, CACOP_INIT,      32'h0007_8204, 1'b1, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0007_8204, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0007_8200, 1'b0, 1'b1},
    // index invalidate of way 0 in set 0x20
    '{1'b1, CACOP_INDEX_INV, 32'h0000_0200, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0007_8200, 1'b0, 1'b0},
    '{1'b1, CACOP_HIT_INV,   32'h0007_8200, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0007_8208, 1'b0, 1'b1},
    // init of way 1 in set 0x10
    '{1'b1, CACOP_INIT,      32'h0000_0101, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0003_4100, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0005_6104, 1'b0, 1'b1},
    '{1'b0, CACOP_INIT,      32'h0005_6100, 1'b1, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0005_6100, 1'b0, 1'b1},
    // scattered sets
    '{1'b0, CACOP_INIT,      32'hABCD_E3F0, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h1234_5FF8, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'hABCD_E3F4, 1'b0, 1'b1},
    '{1'b0, CACOP_INIT,      32'h1234_5FF0, 1'b0, 1'b1},
    '{1'b0, CACOP_INIT,      32'h0000_0000, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'hFFFF_F00C, 1'b0, 1'b0},
    '{1'b0, CACOP_INIT,      32'h0000_0004, 1'b0, 1'b1},
    '{1'b0, CACOP_INIT,      32'hFFFF_F000, 1'b0, 1'b1}
};

`endif

// ==== verif/tb_icache.sv ====
/*
 * icache testbench: runs the case table through the cache against
 * a stalling bridge model and a reference model of the sets
 */
`timescale 1ns/100ps

module tb_icache
    import icache_pkg::*;
    import icache_bus_pkg::*;
();

    logic        clock;
    logic        reset;
    logic        valid_i;
    fetch_req_t  fetch_i;
    cacop_req_t  cacop_i;
    logic        ready_o;
    logic        rvalid_o;
    line_t       rdata_o;
    logic        rd_req_o;
    fetch_addr_t rd_addr_o;
    logic        rd_rdy_i = 1'b0;
    mem_ret_t    ret_i = '0;

    `include "tb_icache_cases.svh"

    // reference sets, lru set means way 1 is replaced next
    logic        m_valid [WAYS][SETS];
    tag_t        m_tag   [WAYS][SETS];
    logic        m_lru   [SETS];

    logic [15:0] lfsr_q = 16'd12283;
    logic        br_busy;
    logic [2:0]  br_beat;
    logic [31:0] br_base;
    int          error_count = 0;

    icache_top u_icache_top (
        .clock     (clock),
        .reset     (reset),
        .valid_i   (valid_i),
        .fetch_i   (fetch_i),
        .cacop_i   (cacop_i),
        .ready_o   (ready_o),
        .rvalid_o  (rvalid_o),
        .rdata_o   (rdata_o),
        .rd_req_o  (rd_req_o),
        .rd_addr_o (rd_addr_o),
        .rd_rdy_i  (rd_rdy_i),
        .ret_i     (ret_i)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ****************************************
    // checks
    // ****************************************
    task automatic stop_run();
        error_count++;
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
        assert (got == exp) else begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_true(logic ok, string what);
        assert (ok) else begin
            $display("** Error at %0t ns: %s", $time, what);
            stop_run();
        end
    endtask

    // ****************************************
    // reference model
    // ****************************************
    function automatic logic [31:0] line_base(fetch_addr_t a);
        return {a.tag, a.index, {OFFSET_W{1'b0}}};
    endfunction

    // beat k of line A is A xor k*0x1111
    function automatic line_t model_line(fetch_addr_t a);
        line_t l;
        for (int k = 0; k < BEATS; k++) begin
            l[k*WORD_W +: WORD_W] = line_base(a) ^ (32'(k) * 32'h1111);
        end
        return l;
    endfunction

    function automatic int model_find(fetch_addr_t a);
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[w][a.index] && m_tag[w][a.index] == a.tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic void model_fill(fetch_addr_t a);
        int v;
        if (!m_valid[0][a.index]) begin
            v = 0;
        end else if (!m_valid[1][a.index]) begin
            v = 1;
        end else begin
            v = int'(m_lru[a.index]);
        end
        m_valid[v][a.index] = 1'b1;
        m_tag[v][a.index]   = a.tag;
        m_lru[a.index]      = (v == 0);
    endfunction

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        lfsr_q = lfsr_step(lfsr_q);
        b      = lfsr_q[0];
    endtask

    // bridge: random ready delay, random gaps between beats
    always @(posedge clock) begin : bridge_model
        logic bit_v;
        if (reset) begin
            rd_rdy_i <= 1'b0;
            ret_i    <= '0;
            br_busy  <= 1'b0;
            br_beat  <= '0;
        end else if (!br_busy) begin
            ret_i <= '0;
            if (rd_req_o && rd_rdy_i) begin
                br_busy  <= 1'b1;
                br_base  <= rd_addr_o;
                br_beat  <= '0;
                rd_rdy_i <= 1'b0;
            end else begin
                take_bit(bit_v);
                rd_rdy_i <= bit_v;
            end
        end else if (br_beat == 3'(BEATS)) begin
            ret_i   <= '0;
            br_busy <= 1'b0;
        end else begin
            take_bit(bit_v);
            if (bit_v) begin
                ret_i <= '{valid: 1'b1, last: (br_beat == 3'(BEATS - 1)),
                           data: br_base ^ (32'(br_beat) * 32'h1111)};
                br_beat <= br_beat + 3'd1;
            end else begin
                ret_i <= '0;
            end
        end
    end

    // ****************************************
    // case runners
    // ****************************************
    task automatic run_fetch(case_t c);
        int    way;
        int    cycles;
        logic  expect_read;
        logic  saw_req;
        line_t exp_line;
        way         = model_find(c.addr);
        expect_read = c.uncached || (way < 0);
        exp_line    = model_line(c.addr);
        check_true(expect_read == !c.exp_hit, "case table disagrees with the reference model");
        @(posedge clock);
        valid_i <= 1'b1;
        fetch_i <= '{addr: c.addr, uncached: c.uncached};
        @(negedge clock);
        check_value("ready_o", 128'(ready_o), 128'(1));
        @(posedge clock);
        valid_i <= 1'b0;
        cycles  = 0;
        saw_req = 1'b0;
        do begin
            @(negedge clock);
            cycles++;
            check_value("ready_o", 128'(ready_o), 128'(0));
            if (cycles == 1) begin
                check_value("rd_req_o", 128'(rd_req_o), 128'(expect_read));
            end
            if (rd_req_o) begin
                saw_req = 1'b1;
                check_value("rd_addr_o", 128'(rd_addr_o), 128'(line_base(c.addr)));
            end
        end while (!rvalid_o);
        check_value("rdata_o", rdata_o, exp_line);
        check_value("rd_req_o seen", 128'(saw_req), 128'(expect_read));
        if (expect_read) begin
            check_value("ret_i.last", 128'(ret_i.valid && ret_i.last), 128'(1));
        end else begin
            check_true(cycles == 1, "hit did not return one cycle after acceptance");
        end
        @(negedge clock);
        check_value("ready_o", 128'(ready_o), 128'(1));
        check_value("rvalid_o", 128'(rvalid_o), 128'(0));
        if (!c.uncached) begin
            if (way >= 0) begin
                m_lru[c.addr.index] = (way == 0);
            end else begin
                model_fill(c.addr);
            end
        end
    endtask

    task automatic run_cacop(case_t c);
        @(posedge clock);
        cacop_i <= '{en: 1'b1, op: c.op, addr: c.addr};
        valid_i <= 1'b1;
        fetch_i <= '{addr: c.addr, uncached: 1'b0};
        @(negedge clock);
        check_value("ready_o", 128'(ready_o), 128'(1));
        @(posedge clock);
        cacop_i <= '0;
        valid_i <= 1'b0;
        // fetch raised with the cacop is dropped
        @(negedge clock);
        check_value("ready_o", 128'(ready_o), 128'(1));
        check_value("rd_req_o", 128'(rd_req_o), 128'(0));
        check_value("rvalid_o", 128'(rvalid_o), 128'(0));
        if (c.op == CACOP_INIT || c.op == CACOP_INDEX_INV) begin
            m_valid[c.addr.offset[0]][c.addr.index] = 1'b0;
        end
    endtask

    initial begin : watchdog
        repeat (NUM_CASES * 40) @(posedge clock);
        check_true(1'b0, "watchdog expired before the case table finished");
    end

    initial begin : main
        reset   = 1'b1;
        valid_i = 1'b0;
        fetch_i = '0;
        cacop_i = '0;
        for (int s = 0; s < SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("ready_o", 128'(ready_o), 128'(1));
        check_value("rvalid_o", 128'(rvalid_o), 128'(0));
        check_value("rd_req_o", 128'(rd_req_o), 128'(0));
        for (int i = 0; i < NUM_CASES; i++) begin
            if (case_tab[i].is_cacop) begin
                run_cacop(case_tab[i]);
            end else begin
                run_fetch(case_tab[i]);
            end
        end
        if (error_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

// ==== src/icache_top.sv ====
/*
 * icache top: joins the fetch controller, the refill collector
 * and the two-way store
 */
`timescale 1ns/100ps

module icache_top
    import icache_pkg::*;
    import icache_bus_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    // cpu side
    input  logic        valid_i,
    input  fetch_req_t  fetch_i,
    input  cacop_req_t  cacop_i,
    output logic        ready_o,
    output logic        rvalid_o,
    output line_t       rdata_o,

    // read bridge
    output logic        rd_req_o,
    output fetch_addr_t rd_addr_o,
    input  logic        rd_rdy_i,
    input  mem_ret_t    ret_i
);

    logic     rd_en;
    index_t   rd_index;
    tag_t     req_tag;
    logic     fill_en;
    index_t   fill_index;
    logic     inv_en;
    way_sel_t inv_way;
    logic     hit;
    line_t    hit_line;
    logic     refill_start;
    logic     refill_done;
    line_t    refill_line;

    icache_ctrl u_ctrl (
        .clock           (clock),
        .reset           (reset),
        .valid_i         (valid_i),
        .fetch_i         (fetch_i),
        .cacop_i         (cacop_i),
        .ready_o         (ready_o),
        .rvalid_o        (rvalid_o),
        .rdata_o         (rdata_o),
        .rd_req_o        (rd_req_o),
        .rd_addr_o       (rd_addr_o),
        .rd_rdy_i        (rd_rdy_i),
        .rd_en_o         (rd_en),
        .rd_index_o      (rd_index),
        .req_tag_o       (req_tag),
        .fill_en_o       (fill_en),
        .fill_index_o    (fill_index),
        .inv_en_o        (inv_en),
        .inv_way_o       (inv_way),
        .hit_i           (hit),
        .hit_line_i      (hit_line),
        .refill_start_o  (refill_start),
        .refill_done_i   (refill_done),
        .refill_line_i   (refill_line)
    );

    refill_collector u_refill (
        .clock   (clock),
        .reset   (reset),
        .start_i (refill_start),
        .ret_i   (ret_i),
        .done_o  (refill_done),
        .line_o  (refill_line)
    );

    icache_ways u_ways (
        .clock        (clock),
        .reset        (reset),
        .rd_en_i      (rd_en),
        .rd_index_i   (rd_index),
        .req_tag_i    (req_tag),
        .fill_en_i    (fill_en),
        .fill_index_i (fill_index),
        .fill_line_i  (refill_line),
        .inv_en_i     (inv_en),
        .inv_way_i    (inv_way),
        .hit_o        (hit),
        .hit_line_o   (hit_line)
    );

endmodule

// ==== src/icache_ways.sv ====
/*
 * icache way store: tag, valid and data for two ways, hit check,
 * per-set LRU bit and victim choice on refill
 */
`timescale 1ns/100ps

module icache_ways
    import icache_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     rd_en_i,
    input  index_t   rd_index_i,
    input  tag_t     req_tag_i,
    input  logic     fill_en_i,
    input  index_t   fill_index_i,
    input  line_t    fill_line_i,
    input  logic     inv_en_i,
    input  way_sel_t inv_way_i,
    output logic     hit_o,
    output line_t    hit_line_o
);

    tag_t            tag_mem  [WAYS][SETS];
    line_t           data_mem [WAYS][SETS];
    logic [SETS-1:0] valid_q  [WAYS];
    // set bit means way 1 is least recently used
    logic [SETS-1:0] lru_q;

    tag_t     tag_rd_q  [WAYS];
    line_t    data_rd_q [WAYS];
    way_sel_t valid_rd_q;
    index_t   rd_index_q;
    logic     lookup_q;

    way_sel_t hit_way;
    way_sel_t set_valid;
    way_sel_t victim;

    // ****************************************
    // hit detection
    // ****************************************
    always_comb begin
        hit_line_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = valid_rd_q[w] && (tag_rd_q[w] == req_tag_i);
            hit_line_o = hit_line_o | ({LINE_W{hit_way[w]}} & data_rd_q[w]);
        end
    end

    assign hit_o = |hit_way;

    // victim: first invalid way, else the LRU one
    always_comb begin
        victim = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            set_valid[w] = valid_q[w][rd_index_q];
            if (!set_valid[w]) begin
                victim = way_sel_t'(1) << w;
            end
        end
        if (victim == '0) begin
            victim = way_sel_t'(1) << lru_q[rd_index_q];
        end
    end

    // ****************************************
    // valid and lru state
    // ****************************************
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_q[w] <= '0;
            end
            lru_q      <= '0;
            valid_rd_q <= '0;
            lookup_q   <= 1'b0;
        end else begin
            lookup_q <= rd_en_i;
            for (int w = 0; w < WAYS; w++) begin
                if (rd_en_i) begin
                    valid_rd_q[w] <= valid_q[w][rd_index_i];
                end
                if (fill_en_i && victim[w]) begin
                    valid_q[w][fill_index_i] <= 1'b1;
                end
                if (inv_en_i && inv_way_i[w]) begin
                    valid_q[w][fill_index_i] <= 1'b0;
                end
            end
            // point lru away from the way just used
            if (fill_en_i) begin
                lru_q[fill_index_i] <= victim[0];
            end else if (lookup_q && hit_o) begin
                lru_q[rd_index_q] <= hit_way[0];
            end
        end
    end

    // arrays and registered read
    always_ff @(posedge clock) begin
        if (rd_en_i) begin
            rd_index_q <= rd_index_i;
            for (int w = 0; w < WAYS; w++) begin
                tag_rd_q[w]  <= tag_mem[w][rd_index_i];
                data_rd_q[w] <= data_mem[w][rd_index_i];
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            if (fill_en_i && victim[w]) begin
                tag_mem[w][fill_index_i]  <= req_tag_i;
                data_mem[w][fill_index_i] <= fill_line_i;
            end
        end
    end

    // a line lives in at most one way, fills happen only on a miss
    a_hit_onehot: assert property (
        @(posedge clock) disable iff (reset) lookup_q |-> $onehot0(hit_way));

endmodule

// ==== icache_ctrl/icache_ctrl.sv ====
/*
 * icache fetch controller
 * runs the fetch FSM and request register, drives the bridge read
 * and selects the returned line
 */
`timescale 1ns/100ps

module icache_ctrl
    import icache_pkg::*;
    import icache_bus_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    input  logic        valid_i,
    input  fetch_req_t  fetch_i,
    input  cacop_req_t  cacop_i,
    output logic        ready_o,
    output logic        rvalid_o,
    output line_t       rdata_o,

    output logic        rd_req_o,
    output fetch_addr_t rd_addr_o,
    input  logic        rd_rdy_i,

    // way store
    output logic        rd_en_o,
    output index_t      rd_index_o,
    output tag_t        req_tag_o,
    output logic        fill_en_o,
    output index_t      fill_index_o,
    output logic        inv_en_o,
    output way_sel_t    inv_way_o,
    input  logic        hit_i,
    input  line_t       hit_line_i,

    // refill collector
    output logic        refill_start_o,
    input  logic        refill_done_i,
    input  line_t       refill_line_i
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REQUEST,
        RECEIVE
    } state_e;

    state_e state_q;

    tag_t   req_tag_q;
    index_t req_index_q;
    logic   req_uncached_q;

    logic   fetch_accept;
    logic   cacop_fire;
    logic   lookup_ret;
    logic   receive_ret;

    // ****************************************
    // cpu side
    // ****************************************
    assign ready_o      = (state_q == IDLE);
    // cacop wins over a fetch in the same cycle
    assign cacop_fire   = ready_o && cacop_i.en;
    assign fetch_accept = ready_o && valid_i && !cacop_i.en;

    assign lookup_ret  = (state_q == LOOKUP) && hit_i;
    assign receive_ret = (state_q == RECEIVE) && refill_done_i;
    assign rvalid_o    = lookup_ret || receive_ret;
    assign rdata_o     = lookup_ret ? hit_line_i : refill_line_i;

    // ****************************************
    // bridge side
    // ****************************************
    assign rd_req_o       = ((state_q == LOOKUP) && !hit_i) || (state_q == REQUEST);
    assign rd_addr_o      = '{tag: req_tag_q, index: req_index_q, offset: '0};
    assign refill_start_o = rd_req_o && rd_rdy_i;

    // way store controls
    assign rd_en_o    = fetch_accept && !fetch_i.uncached;
    assign rd_index_o = fetch_i.addr.index;
    assign req_tag_o  = req_tag_q;
    assign fill_en_o  = receive_ret && !req_uncached_q;
    assign inv_en_o   = cacop_fire &&
                        ((cacop_i.op == CACOP_INIT) || (cacop_i.op == CACOP_INDEX_INV));
    assign inv_way_o  = way_sel_t'(1) << cacop_i.addr.offset[0];

    // fill and invalidate never overlap and share one index
    assign fill_index_o = inv_en_o ? cacop_i.addr.index : req_index_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q        <= IDLE;
            req_uncached_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (fetch_accept) begin
                        req_uncached_q <= fetch_i.uncached;
                        state_q        <= fetch_i.uncached ? REQUEST : LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit_i) begin
                        state_q <= IDLE;
                    end else if (rd_rdy_i) begin
                        state_q <= RECEIVE;
                    end else begin
                        state_q <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (rd_rdy_i) begin
                        state_q <= RECEIVE;
                    end
                end
                RECEIVE: begin
                    if (refill_done_i) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // request register
    always_ff @(posedge clock) begin
        if (fetch_accept) begin
            req_tag_q   <= fetch_i.addr.tag;
            req_index_q <= fetch_i.addr.index;
        end
    end

    // a line only ends while a fetch waits for it
    a_no_rvalid_when_ready: assert property (
        @(posedge clock) disable iff (reset) refill_done_i |-> !ready_o);

    // bridge request holds until the handoff
    a_rd_req_stable: assert property (
        @(posedge clock) disable iff (reset)
        rd_req_o && !rd_rdy_i |=> rd_req_o && $stable(rd_addr_o));

endmodule

// ==== icache_ctrl/refill_collector.sv ====
/*
 * refill collector
 * counts bridge return beats and assembles them into one cache line
 */
`timescale 1ns/100ps

module refill_collector
    import icache_pkg::*;
    import icache_bus_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     start_i,
    input  mem_ret_t ret_i,
    output logic     done_o,
    output line_t    line_o
);

    localparam int CNT_W = $clog2(BEATS);

    logic [CNT_W-1:0]  cnt_q;
    logic              active_q;
    logic [WORD_W-1:0] beat_q [BEATS-1];
    logic              beat_take;

    assign beat_take = active_q && ret_i.valid;
    // an early last also ends the line
    assign done_o    = beat_take && (ret_i.last || (cnt_q == CNT_W'(BEATS - 1)));

    // live beat goes straight into the top word
    always_comb begin
        line_o = '0;
        for (int k = 0; k < BEATS - 1; k++) begin
            line_o[k*WORD_W +: WORD_W] = beat_q[k];
        end
        line_o[LINE_W-1 -: WORD_W] = ret_i.data;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cnt_q    <= '0;
            active_q <= 1'b0;
        end else if (start_i) begin
            cnt_q    <= '0;
            active_q <= 1'b1;
        end else if (done_o) begin
            active_q <= 1'b0;
        end else if (beat_take) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (beat_take && !done_o) begin
            beat_q[cnt_q] <= ret_i.data;
        end
    end

    // bridge stays quiet between line end and the next handoff
    a_no_extra_beat: assert property (
        @(posedge clock) disable iff (reset)
        !active_q |-> !ret_i.valid);

endmodule

// ==== common/icache_bus_pkg.sv ====
/*
 * icache bus types: CPU fetch and cache-op requests,
 * and the return beats coming back from the read bridge
 */
package icache_bus_pkg;

    // cache operation codes, taken from code[4:3]
    typedef enum logic [1:0] {
        CACOP_INIT      = 2'd0,
        CACOP_INDEX_INV = 2'd1,
        // accepted, no effect on this cache
        CACOP_HIT_INV   = 2'd2
    } cacop_op_e;

    typedef struct packed {
        logic                     en;
        cacop_op_e                op;
        icache_pkg::fetch_addr_t  addr;
    } cacop_req_t;

    typedef struct packed {
        icache_pkg::fetch_addr_t  addr;
        logic                     uncached;
    } fetch_req_t;

    // one 32-bit beat of a line read
    typedef struct packed {
        logic                          valid;
        logic                          last;
        logic [icache_pkg::WORD_W-1:0] data;
    } mem_ret_t;

endpackage

// ==== common/icache_pkg.sv ====
/*
 * icache geometry: constants for the 2-way, 256-set, 16-byte-line
 * instruction cache, plus the address, tag and line types
 */
package icache_pkg;

    // ****************************************
    // geometry
    // ****************************************
    localparam int WAYS     = 2;
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;
    localparam int SETS     = 1 << INDEX_W;

    // refill beats from the bridge
    localparam int BEATS    = 4;
    localparam int WORD_W   = 32;
    localparam int LINE_W   = BEATS * WORD_W;

    // ****************************************
    // types
    // ****************************************
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // beat 0 in the low word
    typedef logic [LINE_W-1:0]  line_t;

    // one-hot way select
    typedef logic [WAYS-1:0]    way_sel_t;

    typedef struct packed {
        tag_t                tag;
        index_t              index;
        logic [OFFSET_W-1:0] offset;
    } fetch_addr_t;

endpackage
